// File: hw/dcache_pkg.sv
// cache geometry, address view and load size type, imported by every cache RTL file
package dcache_pkg;

    localparam int WAYS       = 2;
    localparam int LINE_WORDS = 4;
    localparam int SETS       = 64;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 6;
    localparam int TAG_W      = 22;

    // one cache line, word 0 in the low bits
    typedef logic [LINE_WORDS-1:0][31:0] line_t;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [1:0]         word;     // word within the line
        logic [1:0]         byte_ofs; // byte within the word
    } addr_fields_t;

    // cpu and memory use the flat word, the cache uses the fields
    typedef union packed {
        logic [31:0]  flat;
        addr_fields_t fld;
    } addr_u;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } load_size_t;

endpackage

// File: hw/cache_array_if.sv
// connects the cache controller to the tag, dirty and line storage; ctrl and store modports
`timescale 1ns/100ps

interface cache_array_if import dcache_pkg::*; ();

    logic [INDEX_W-1:0]            rd_index;
    logic [WAYS-1:0]               valid;
    logic [WAYS-1:0][TAG_W-1:0]    tag;
    logic [WAYS-1:0]               dirty;
    line_t [WAYS-1:0]              line;

    logic [WAYS-1:0]               tag_we;    // also sets valid
    logic [TAG_W-1:0]              tag_wdata;
    logic [WAYS-1:0]               dirty_we;
    logic                          dirty_wdata;
    logic [WAYS-1:0]               data_we;
    logic [INDEX_W-1:0]            wr_index;  // shared by all write ports
    line_t                         wr_line;

    modport ctrl (
        output rd_index, tag_we, tag_wdata, dirty_we, dirty_wdata, data_we, wr_index, wr_line,
        input  valid, tag, dirty, line
    );

    modport store (
        input  rd_index, tag_we, tag_wdata, dirty_we, dirty_wdata, data_we, wr_index, wr_line,
        output valid, tag, dirty, line
    );

endinterface

// File: hw/cache_arrays.sv
// valid, tag, dirty and line storage for both ways; instantiated once under the cache top
`timescale 1ns/100ps

module cache_arrays import dcache_pkg::*; (
    input logic          clk,
    input logic          reset,
    cache_array_if.store arr
);

    logic [SETS-1:0]    valid_q [WAYS];
    logic [TAG_W-1:0]   tag_mem [WAYS][SETS];
    logic               dirty_mem [WAYS][SETS];
    line_t              data_mem [WAYS][SETS];
    logic [INDEX_W-1:0] rd_index_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_index_q <= '0;
        end else begin
            rd_index_q <= arr.rd_index;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (arr.tag_we[w]) begin
                    valid_q[w][arr.wr_index] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (arr.tag_we[w]) begin
                tag_mem[w][arr.wr_index] <= arr.tag_wdata;
            end
            if (arr.dirty_we[w]) begin
                dirty_mem[w][arr.wr_index] <= arr.dirty_wdata;
            end
        end
    end

    // tag side reads through the registered index, so earlier writes are seen
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            arr.valid[w] = valid_q[w][rd_index_q];
            arr.tag[w]   = tag_mem[w][rd_index_q];
            arr.dirty[w] = dirty_mem[w][rd_index_q];
        end
    end

    // line store, read-first on a same-set write
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (arr.data_we[w]) begin
                data_mem[w][arr.wr_index] <= arr.wr_line;
            end
            arr.line[w] <= data_mem[w][arr.rd_index];
        end
    end

endmodule

// File: hw/dcache_ctrl.sv
// cache controller with lookup stage, miss FSM, LRU, store buffer and collision stall
`timescale 1ns/100ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  logic        req_write,
    input  addr_u       req_addr,
    input  logic [3:0]  req_wstrb,
    input  logic [31:0] req_wdata,
    input  load_size_t  req_size,
    input  logic        req_signed,
    output logic        busy,
    output logic        rsp_valid,
    output addr_u       word_sel,
    output line_t       line_sel,
    output load_size_t  size_sel,
    output logic        signed_sel,
    output logic        mem_rd_req,
    output logic [31:0] mem_rd_addr,
    input  logic        mem_rd_done,
    input  line_t       mem_rd_line,
    output logic        mem_wr_req,
    output logic [31:0] mem_wr_addr,
    output line_t       mem_wr_line,
    input  logic        mem_wr_done,
    cache_array_if.ctrl arr
);

    typedef enum logic [1:0] {lookup, miss_dirty, miss_clean, refill_done} state_t;

    state_t state, state_next;

    // request in the lookup stage
    logic        lk_valid;
    logic        lk_write;
    addr_u       lk_addr;
    logic [3:0]  lk_wstrb;
    logic [31:0] lk_wdata;
    load_size_t  lk_size;
    logic        lk_signed;

    logic [WAYS-1:0] hit;
    logic            any_hit;
    logic            hit_way;
    logic [SETS-1:0] lru;      // way to evict next
    logic            victim;
    logic [WAYS-1:0] victim_oh;
    logic            miss_busy;
    logic            col_lookup;
    logic            col_buffer;
    logic            capture;
    logic            refill_wr;
    line_t           merged_line;

    logic               sb_valid;
    logic [WAYS-1:0]    sb_way;
    logic [INDEX_W-1:0] sb_index;
    logic [TAG_W-1:0]   sb_tag;
    line_t              sb_line;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = arr.valid[w] && (arr.tag[w] == lk_addr.fld.tag);
        end
    end

    assign any_hit   = |hit;
    assign hit_way   = hit[1];
    assign victim    = lru[lk_addr.fld.index];
    assign victim_oh = {victim, !victim};
    assign refill_wr = (state == miss_clean) && mem_rd_done;

    // held until the re-lookup hits
    assign miss_busy  = lk_valid && !((state == lookup) && any_hit);
    assign col_lookup = (state == lookup) && lk_valid && lk_write
                        && (lk_addr.flat[31:OFFSET_W] == req_addr.flat[31:OFFSET_W]);
    assign col_buffer = sb_valid && ({sb_tag, sb_index} == req_addr.flat[31:OFFSET_W]);
    assign busy       = miss_busy || (req_valid && (col_lookup || col_buffer));
    assign capture    = req_valid && !busy;
    assign rsp_valid  = (state == lookup) && lk_valid && any_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            lk_valid <= 1'b0;
        end else if (!miss_busy) begin
            lk_valid <= capture; // bubble on a collision stall
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            lk_write  <= req_write;
            lk_addr   <= req_addr;
            lk_wstrb  <= req_wstrb;
            lk_wdata  <= req_wdata;
            lk_size   <= req_size;
            lk_signed <= req_signed;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lookup;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            lookup: begin
                if (lk_valid && !any_hit) begin
                    state_next = (arr.valid[victim] && arr.dirty[victim]) ? miss_dirty : miss_clean;
                end
            end
            miss_dirty: if (mem_wr_done) state_next = miss_clean;
            miss_clean: if (mem_rd_done) state_next = refill_done;
            default:    state_next = lookup; // re-read cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (rsp_valid) begin
            lru[lk_addr.fld.index] <= !hit_way;
        end else if (refill_wr) begin
            lru[lk_addr.fld.index] <= !victim;
        end
    end

    always_comb begin
        merged_line = arr.line[hit_way];
        for (int b = 0; b < 4; b++) begin
            if (lk_wstrb[b]) begin
                merged_line[lk_addr.fld.word][8*b +: 8] = lk_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sb_valid <= 1'b0;
        end else begin
            sb_valid <= rsp_valid && lk_write;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid && lk_write) begin
            sb_way   <= hit;
            sb_index <= lk_addr.fld.index;
            sb_tag   <= lk_addr.fld.tag;
            sb_line  <= merged_line;
        end
    end

    // refill and store buffer writes never fall in the same cycle
    assign arr.rd_index    = miss_busy ? lk_addr.fld.index : req_addr.fld.index;
    assign arr.tag_we      = refill_wr ? victim_oh : '0;
    assign arr.tag_wdata   = lk_addr.fld.tag;
    assign arr.dirty_we    = refill_wr ? victim_oh : (sb_valid ? sb_way : '0);
    assign arr.dirty_wdata = !refill_wr;
    assign arr.data_we     = refill_wr ? victim_oh : (sb_valid ? sb_way : '0);
    assign arr.wr_index    = refill_wr ? lk_addr.fld.index : sb_index;
    assign arr.wr_line     = refill_wr ? mem_rd_line : sb_line;

    assign mem_rd_req  = (state == miss_clean);
    assign mem_rd_addr = {lk_addr.fld.tag, lk_addr.fld.index, {OFFSET_W{1'b0}}};
    assign mem_wr_req  = (state == miss_dirty);
    assign mem_wr_addr = {arr.tag[victim], lk_addr.fld.index, {OFFSET_W{1'b0}}};
    assign mem_wr_line = arr.line[victim];

    assign word_sel   = lk_addr;
    assign line_sel   = arr.line[hit_way];
    assign size_sel   = lk_size;
    assign signed_sel = lk_signed;

endmodule

// File: hw/load_align.sv
// picks the addressed word from a line and extends a byte or halfword load
`timescale 1ns/100ps

module load_align import dcache_pkg::*; (
    input  line_t       line,
    input  addr_u       addr,
    input  load_size_t  size,
    input  logic        is_signed,
    output logic [31:0] rdata
);

    logic [31:0] word;
    logic [15:0] half;
    logic [7:0]  bsel;

    always_comb begin
        word = line[addr.fld.word];
        half = addr.fld.byte_ofs[1] ? word[31:16] : word[15:0];
        bsel = word[8*addr.fld.byte_ofs +: 8];

        case (size)
            size_byte: rdata = {{24{is_signed & bsel[7]}}, bsel};
            size_half: rdata = {{16{is_signed & half[15]}}, half};
            default:   rdata = word;
        endcase
    end

endmodule

// File: hw/dcache_top.sv
// two-way write-back data cache top level with cpu and line-wide memory ports
`timescale 1ns/100ps

module dcache_top import dcache_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         req_valid,
    input  logic         req_write,
    input  logic [31:0]  req_addr,
    input  logic [3:0]   req_wstrb,
    input  logic [31:0]  req_wdata,
    input  load_size_t   req_size,
    input  logic         req_signed,
    output logic         busy,
    output logic         rsp_valid,
    output logic [31:0]  rsp_rdata,
    output logic         mem_rd_req,
    output logic [31:0]  mem_rd_addr,
    input  logic         mem_rd_done,
    input  logic [127:0] mem_rd_line,
    output logic         mem_wr_req,
    output logic [31:0]  mem_wr_addr,
    output logic [127:0] mem_wr_line,
    input  logic         mem_wr_done
);

    addr_u      word_sel;
    line_t      line_sel;
    load_size_t size_sel;
    logic       signed_sel;

    cache_array_if arr_if ();

    dcache_ctrl u_ctrl (
        .clk, .reset,
        .req_valid, .req_write, .req_addr, .req_wstrb, .req_wdata, .req_size, .req_signed,
        .busy, .rsp_valid,
        .word_sel, .line_sel, .size_sel, .signed_sel,
        .mem_rd_req, .mem_rd_addr, .mem_rd_done, .mem_rd_line,
        .mem_wr_req, .mem_wr_addr, .mem_wr_line, .mem_wr_done,
        .arr (arr_if.ctrl)
    );

    cache_arrays u_arrays (
        .clk, .reset,
        .arr (arr_if.store)
    );

    load_align u_align (
        .line      (line_sel),
        .addr      (word_sel),
        .size      (size_sel),
        .is_signed (signed_sel),
        .rdata     (rsp_rdata)
    );

endmodule

// File: bench/dcache_properties.sv
// protocol assertions for the cache controller, bound into every dcache_ctrl instance
`timescale 1ns/100ps

module dcache_properties import dcache_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        capture,
    input logic        req_write,
    input addr_u       req_addr,
    input addr_u       lk_addr,
    input logic        rsp_valid,
    input logic        mem_rd_req,
    input logic [31:0] mem_rd_addr,
    input logic        mem_rd_done,
    input logic        mem_wr_req,
    input logic [31:0] mem_wr_addr,
    input logic        mem_wr_done
);

    int fail_count = 0;

    one_request: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd_req && mem_wr_req))
        else begin
            fail_count++;
            $error("read and write requests high together");
        end

    rd_aligned: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req |-> mem_rd_addr[OFFSET_W-1:0] == '0)
        else begin
            fail_count++;
            $error("mem_rd_addr not line aligned");
        end

    wr_aligned: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req |-> mem_wr_addr[OFFSET_W-1:0] == '0)
        else begin
            fail_count++;
            $error("mem_wr_addr not line aligned");
        end

    // a request is a level held with its address until done
    rd_held: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req && !mem_rd_done |=> mem_rd_req && $stable(mem_rd_addr))
        else begin
            fail_count++;
            $error("read request dropped before done");
        end

    wr_held: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req && !mem_wr_done |=> mem_wr_req && $stable(mem_wr_addr))
        else begin
            fail_count++;
            $error("write request dropped before done");
        end

    // response only after the re-read cycle that follows the refill
    rsp_after_refill: assert property (@(posedge clk) disable iff (reset)
        $past(mem_rd_req && mem_rd_done, 2) |-> rsp_valid && !$past(rsp_valid))
        else begin
            fail_count++;
            $error("miss response not given right after the refill re-read");
        end

    // a load to the line now hitting in lookup hits again one cycle later
    load_hit_latency: assert property (@(posedge clk) disable iff (reset)
        capture && !req_write && rsp_valid
        && req_addr.flat[31:OFFSET_W] == lk_addr.flat[31:OFFSET_W] |=> rsp_valid)
        else begin
            fail_count++;
            $error("load hit without rsp_valid one cycle after capture");
        end

endmodule

bind dcache_ctrl dcache_properties props (
    .clk, .reset, .capture, .req_write, .req_addr, .lk_addr, .rsp_valid,
    .mem_rd_req, .mem_rd_addr, .mem_rd_done, .mem_wr_req, .mem_wr_addr, .mem_wr_done
);

// File: bench/tb_dcache.sv
// testbench for the data cache: memory and reference models, directed and random tests
`timescale 1ns/100ps

module tb_dcache import dcache_pkg::*; ();

    localparam logic [31:0] fill_key   = 32'h5a3c_96e1;
    localparam int          random_ops = 400;
    localparam int          request_count = 1 + 1 + 2 + 13 + 4 + random_ops;
    localparam int          cycle_limit = 8 + 200 * request_count;

    logic         clk;
    logic         reset;
    logic         req_valid;
    logic         req_write;
    logic [31:0]  req_addr;
    logic [3:0]   req_wstrb;
    logic [31:0]  req_wdata;
    load_size_t   req_size;
    logic         req_signed;
    logic         busy;
    logic         rsp_valid;
    logic [31:0]  rsp_rdata;
    logic         mem_rd_req;
    logic [31:0]  mem_rd_addr;
    logic         mem_rd_done;
    logic [127:0] mem_rd_line;
    logic         mem_wr_req;
    logic [31:0]  mem_wr_addr;
    logic [127:0] mem_wr_line;
    logic         mem_wr_done;

    logic [31:0] mem_words [bit [31:0]];
    logic [7:0]  ref_bytes [bit [31:0]];
    logic [32:0] expected [$];           // {is_load, load word}
    logic [31:0] last_rd_addr;
    logic [31:0] last_wr_addr;
    int cycles = 0;
    int errors = 0;
    int mismatches = 0;
    int stray_responses = 0;
    int checks = 0;
    int resp_count = 0;
    int rd_count = 0;
    int wr_count = 0;
    int wr_at_rd_count = 0;
    int last_stalls = 0;
    int tests = 0;
    int prev_errors = 0;

    dcache_top DUT (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ fill_key;
    endfunction

    function automatic logic [31:0] mem_word(logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [7:0] ref_byte(logic [31:0] addr);
        logic [31:0] w;
        if (ref_bytes.exists(addr)) begin
            return ref_bytes[addr];
        end
        w = fill_word(addr);
        return w[8*addr[1:0] +: 8];
    endfunction

    // byte model view of a load, extended by size and sign
    function automatic logic [31:0] expect_load(logic [31:0] addr, load_size_t size, logic sgn);
        logic [31:0] base;
        logic [7:0]  b;
        logic [15:0] h;
        base = {addr[31:2], 2'b00};
        b    = ref_byte(addr);
        h    = {ref_byte(base + {30'd0, addr[1], 1'b1}), ref_byte(base + {30'd0, addr[1], 1'b0})};
        case (size)
            size_byte: return {{24{sgn & b[7]}}, b};
            size_half: return {{16{sgn & h[15]}}, h};
            default:   return {ref_byte(base + 3), ref_byte(base + 2), ref_byte(base + 1),
                               ref_byte(base)};
        endcase
    endfunction

    function automatic int total_errors();
        return errors + mismatches + stray_responses + DUT.u_ctrl.props.fail_count;
    endfunction

    // line memory, answers after 1 to 6 cycles
    initial begin : memory_model
        int delay;
        mem_rd_done = 1'b0;
        mem_wr_done = 1'b0;
        mem_rd_line = '0;
        forever begin
            @(negedge clk);
            if (!reset && (mem_rd_req || mem_wr_req)) begin
                delay = 1 + int'($urandom % 6);
                repeat (delay) @(posedge clk);
                #5;
                if (mem_wr_req) begin
                    for (int i = 0; i < 4; i++) begin
                        mem_words[mem_wr_addr + 4*i] = mem_wr_line[32*i +: 32];
                    end
                    last_wr_addr   = mem_wr_addr;
                    wr_at_rd_count = rd_count;
                    wr_count++;
                    mem_wr_done = 1'b1;
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        mem_rd_line[32*i +: 32] = mem_word(mem_rd_addr + 4*i);
                    end
                    last_rd_addr = mem_rd_addr;
                    rd_count++;
                    mem_rd_done = 1'b1;
                end
                @(posedge clk);
                #5;
                mem_rd_done = 1'b0;
                mem_wr_done = 1'b0;
            end
        end
    end

    // responses come back in capture order
    always @(negedge clk) begin : response_check
        logic [32:0] entry;
        if (!reset && rsp_valid) begin
            if (resp_count >= expected.size()) begin
                $display("error at %0t: response with no request outstanding", $time);
                stray_responses++;
            end else begin
                entry = expected[resp_count];
                resp_count++;
                if (entry[32]) begin
                    checks++;
                    assert (rsp_rdata == entry[31:0])
                    else begin
                        $display("mismatch at %0t: rsp_rdata got %h expected %h",
                                 $time, rsp_rdata, entry[31:0]);
                        mismatches++;
                    end
                end
            end
        end
    end

    task automatic issue(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
                         input logic [31:0] data, input load_size_t size, input logic sgn);
        logic was_busy;
        req_valid   = 1'b1;
        req_write   = wr;
        req_addr    = addr;
        req_wstrb   = strb;
        req_wdata   = data;
        req_size    = size;
        req_signed  = sgn;
        last_stalls = 0;
        do begin
            @(negedge clk);
            was_busy = busy;
            @(posedge clk);
            #5;
            if (was_busy) begin
                last_stalls++;
            end
        end while (was_busy);
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    ref_bytes[{addr[31:2], 2'b00} + b] = data[8*b +: 8];
                end
            end
            expected.push_back({1'b0, 32'h0});
        end else begin
            expected.push_back({1'b1, expect_load(addr, size, sgn)});
        end
        req_valid = 1'b0;
    endtask

    task automatic load(input logic [31:0] addr, input load_size_t size, input logic sgn);
        issue(1'b0, addr, 4'h0, 32'h0, size, sgn);
    endtask

    task automatic store(input logic [31:0] addr, input logic [3:0] strb,
                         input logic [31:0] data);
        issue(1'b1, addr, strb, data, size_word, 1'b0);
    endtask

    task automatic wait_idle();
        while (resp_count < expected.size()) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, total_errors() - prev_errors);
        prev_errors = total_errors();
    endtask

    initial begin : stimulus
        logic [31:0] line_a;
        logic [31:0] set_a;
        logic [31:0] addr;
        int rd_before;
        int wr_before;
        int sel;
        void'($urandom(73));
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wstrb  = '0;
        req_wdata  = '0;
        req_size   = size_word;
        req_signed = 1'b0;
        line_a     = 32'h0000_0140;
        set_a      = 32'h0000_0230;
        repeat (8) @(posedge clk);
        #5;
        reset = 1'b0;

        rd_before = rd_count;
        load(line_a + 4, size_word, 1'b0);
        wait_idle();
        assert (rd_count == rd_before + 1)
        else begin
            $display("error: load to an empty cache did not read its line from memory");
            errors++;
        end
        assert (last_rd_addr == line_a)
        else begin
            $display("mismatch at %0t: mem_rd_addr got %h expected %h", $time,
                     last_rd_addr, line_a);
            errors++;
        end
        end_test("cold load");

        rd_before = rd_count;
        load(line_a + 8, size_word, 1'b0);
        @(posedge clk); // response counted at the negedge after capture
        #5;
        assert (resp_count == expected.size())
        else begin
            $display("error: load hit gave no response in the cycle after capture");
            errors++;
        end
        wait_idle();
        assert (rd_count == rd_before)
        else begin
            $display("error: load to a cached line went out to memory");
            errors++;
        end
        end_test("load hit");

        store(line_a + 4, 4'b0101, 32'hdead_beef);
        load(line_a + 4, size_word, 1'b0);
        assert (last_stalls > 0)
        else begin
            $display("error: load right after a store to the same word never saw busy");
            errors++;
        end
        wait_idle();
        end_test("store then load");

        store(line_a + 8, 4'hf, 32'h80ff_7f01); // both signs in bytes and halves
        for (int k = 0; k < 8; k++) begin
            load(line_a + 8 + 32'(k / 2), size_byte, k[0]);
        end
        for (int k = 0; k < 4; k++) begin
            load(line_a + 8 + 32'(2 * (k / 2)), size_half, k[0]);
        end
        wait_idle();
        end_test("byte and half loads");

        store(set_a, 4'b0110, 32'h1234_5678);
        load(set_a + 32'h400, size_word, 1'b0);
        wait_idle();
        rd_before = rd_count;
        wr_before = wr_count;
        load(set_a + 32'h800, size_word, 1'b0);
        wait_idle();
        assert (wr_count == wr_before + 1 && wr_at_rd_count == rd_before)
        else begin
            $display("error: dirty victim was not written back before the refill");
            errors++;
        end
        assert (last_wr_addr == set_a)
        else begin
            $display("mismatch at %0t: mem_wr_addr got %h expected %h", $time,
                     last_wr_addr, set_a);
            errors++;
        end
        assert (mem_word(set_a) == expect_load(set_a, size_word, 1'b0))
        else begin
            $display("mismatch at %0t: mem_wr_line got %h expected %h", $time,
                     mem_word(set_a), expect_load(set_a, size_word, 1'b0));
            errors++;
        end
        load(set_a, size_word, 1'b0);
        wait_idle();
        end_test("lru eviction");

        for (int i = 0; i < random_ops; i++) begin
            addr = 32'h0000_4000 + ($urandom % 32'h1000);
            if ($urandom % 2) begin
                store({addr[31:2], 2'b00}, 4'($urandom), $urandom);
            end else begin
                sel = int'($urandom % 3);
                case (sel)
                    0:       load(addr, size_byte, 1'($urandom));
                    1:       load({addr[31:1], 1'b0}, size_half, 1'($urandom));
                    default: load({addr[31:2], 2'b00}, size_word, 1'b0);
                endcase
            end
        end
        wait_idle();
        end_test("random mix");

        $display("%0d tests, %0d data checks, %0d errors", tests, checks, total_errors());
        if (total_errors() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/dcache_pkg.sv
hw/cache_array_if.sv
hw/cache_arrays.sv
hw/dcache_ctrl.sv
hw/load_align.sv
hw/dcache_top.sv
bench/dcache_properties.sv
bench/tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Simulation completed successfully

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FLIST)))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
